// File: sim.f
common/axi_lite_pkg.sv
common/demux_pkg.sv
logic/select_fifo.sv
logic/req_fanout.sv
logic/resp_mux.sv
demux/demux_ctrl.sv
demux/lite_demux_top.sv
tb/lite_demux_sva.sv
tb/tb_lite_demux.sv

// File: tb/tb_lite_demux.sv
/*
  testbench for the axi4-lite demux
  random master traffic, one slave model per master port and an
  in-order reference of expected routing and responses
*/
`timescale 1ns/1ns

module tb_lite_demux import demux_pkg::*, axi_lite_pkg::*; ();

  localparam int NUM_PORTS = NUM_PORTS_DEF;
  localparam int MAX_TRANS = MAX_TRANS_DEF;
  localparam int SEL_W     = $clog2(NUM_PORTS);
  localparam int N_WR      = 40;              // writes in mixed traffic
  localparam int N_RD      = 40;              // reads in mixed traffic
  localparam int N_ALL     = N_RD + MAX_TRANS + 4; // plus reads of the limit test
  localparam int PERIOD    = 40;

  logic clk_i = 1'b0;
  logic rst_i;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
  logic [ADDR_W-1:0] aw_addr_i, ar_addr_i, m_aw_addr_o, m_ar_addr_o;
  logic [SEL_W-1:0]  aw_sel_i, ar_sel_i;
  logic [DATA_W-1:0] w_data_i, r_data_o, m_w_data_o;
  logic [STRB_W-1:0] w_strb_i, m_w_strb_o;
  resp_e             b_resp_o, r_resp_o;
  logic [NUM_PORTS-1:0] m_aw_valid_o, m_aw_ready_i, m_w_valid_o, m_w_ready_i;
  logic [NUM_PORTS-1:0] m_b_valid_i, m_b_ready_o, m_ar_valid_o, m_ar_ready_i;
  logic [NUM_PORTS-1:0] m_r_valid_i, m_r_ready_o;
  logic [NUM_PORTS-1:0][1:0]        m_b_resp_i, m_r_resp_i;
  logic [NUM_PORTS-1:0][DATA_W-1:0] m_r_data_i;

  // transaction tables filled once from the seed
  logic [ADDR_W-1:0] wr_addr [N_WR];
  logic [SEL_W-1:0]  wr_sel  [N_WR];
  logic [DATA_W-1:0] wr_data [N_WR];
  logic [STRB_W-1:0] wr_strb [N_WR];
  logic [ADDR_W-1:0] rd_addr [N_ALL];
  logic [SEL_W-1:0]  rd_sel  [N_ALL];
  // per-port slave model state
  logic [ADDR_W-1:0] s_aw_addr [NUM_PORTS][N_WR];
  logic [ADDR_W-1:0] s_ar_addr [NUM_PORTS][N_ALL];
  int s_aw_cnt [NUM_PORTS], s_w_cnt [NUM_PORTS], s_ar_cnt [NUM_PORTS];
  int b_shown [NUM_PORTS], b_done [NUM_PORTS]; // raised vs taken
  int r_shown [NUM_PORTS], r_done [NUM_PORTS];
  // stimulus progress as shown vs transferred counts
  int aw_shown, aw_xfer, w_shown, w_xfer, ar_shown, ar_xfer, b_cnt, r_cnt;
  int m_aw_cnt, m_w_cnt, m_ar_cnt;   // transfers seen at master ports
  int ar_limit, lim_base;
  bit run, hold_r, limit_mode;
  int errs [5], checks [5];
  string names [5] = '{"write_routing", "read_routing", "write_resp",
                       "backpressure", "trans_limit"};
  integer seed = 32'h45a3;

  lite_demux_top #(.NUM_PORTS(NUM_PORTS), .MAX_TRANS(MAX_TRANS)) uut (.*);

  always #(PERIOD / 2) clk_i = ~clk_i;

  // bit 0 of the address flags a slave error
  function automatic resp_e slave_resp(input logic [ADDR_W-1:0] addr);
    return addr[0] ? SLVERR : OKAY;
  endfunction

  function automatic bit chance(input int pct);
    return (($random(seed) & 32'h7fff_ffff) % 100) < pct;
  endfunction

  task automatic compare_value(input int test, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
    checks[test]++;
    assert (exp === act) else begin
      $display("FAILED %s %s: expected %0h, actual %0h", names[test], what, exp, act);
      errs[test]++;
    end
  endtask

  task automatic check_true(input int test, input bit cond, input string msg);
    checks[test]++;
    assert (cond) else begin
      $display("error in %s: %s", names[test], msg);
      errs[test]++;
    end
  endtask

  task automatic wait_cycle();
    @(posedge clk_i);
    #1; // clear of the edge
  endtask

  task automatic report_test(input int t);
    $display("test %-14s %0d checks, %0d errors", names[t], checks[t], errs[t]);
  endtask

  // ----------------------------------------------------------
  // stimulus on the falling edge
  // ----------------------------------------------------------
  always @(negedge clk_i) begin
    if (run) begin
      if (aw_shown == aw_xfer && aw_shown < N_WR && chance(50)) begin
        aw_addr_i = wr_addr[aw_shown];
        aw_sel_i  = wr_sel[aw_shown];
        aw_shown++;
      end
      aw_valid_i = (aw_shown > aw_xfer); // held until transfer
      if (w_shown == w_xfer && w_shown < N_WR && chance(50)) begin
        w_data_i = wr_data[w_shown];
        w_strb_i = wr_strb[w_shown];
        w_shown++;
      end
      w_valid_i = (w_shown > w_xfer);
      if (ar_shown == ar_xfer && ar_shown < ar_limit && chance(50)) begin
        ar_addr_i = rd_addr[ar_shown];
        ar_sel_i  = rd_sel[ar_shown];
        ar_shown++;
      end
      ar_valid_i = (ar_shown > ar_xfer);
      b_ready_i  = chance(50); // random back-pressure
      r_ready_i  = chance(50);
      for (int p = 0; p < NUM_PORTS; p++) begin
        m_aw_ready_i[p] = chance(60);
        m_w_ready_i[p]  = chance(60);
        m_ar_ready_i[p] = chance(60);
        // B once both AW and W of the oldest write are in
        if (b_shown[p] == b_done[p] && b_done[p] < s_aw_cnt[p] &&
            b_done[p] < s_w_cnt[p] && chance(40)) begin
          b_shown[p]++;
        end
        m_b_valid_i[p] = (b_shown[p] > b_done[p]);
        m_b_resp_i[p]  = m_b_valid_i[p] ? slave_resp(s_aw_addr[p][b_done[p]]) : OKAY;
        if (r_shown[p] == r_done[p] && r_done[p] < s_ar_cnt[p] && !hold_r && chance(40)) begin
          r_shown[p]++;
        end
        m_r_valid_i[p] = (r_shown[p] > r_done[p]);
        m_r_resp_i[p]  = m_r_valid_i[p] ? slave_resp(s_ar_addr[p][r_done[p]]) : OKAY;
        m_r_data_i[p]  = m_r_valid_i[p] ?
                         DATA_W'(s_ar_addr[p][r_done[p]]) + (DATA_W'(p) << 24) : '0;
      end
    end
  end

  // ----------------------------------------------------------
  // monitor reads pre-edge values on the rising edge
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (run) begin
      if (limit_mode && ar_xfer - lim_base >= MAX_TRANS) begin
        check_true(4, !ar_ready_o, "ar_ready_o high with MAX_TRANS reads open");
      end
      if (aw_valid_i && aw_ready_o) aw_xfer++;
      if (w_valid_i && w_ready_o) w_xfer++;
      if (ar_valid_i && ar_ready_o) ar_xfer++;
      if (b_valid_o && b_ready_i) begin
        check_true(3, b_cnt < w_xfer, "B response with no write open");
        if (b_cnt < N_WR) compare_value(2, "bresp", slave_resp(wr_addr[b_cnt]), b_resp_o);
        b_cnt++;
      end
      if (r_valid_o && r_ready_i) begin
        check_true(3, r_cnt < ar_xfer, "R response with no read open");
        if (r_cnt < N_ALL) begin
          compare_value(1, "rdata", DATA_W'(rd_addr[r_cnt]) + (DATA_W'(rd_sel[r_cnt]) << 24),
                        r_data_o);
          compare_value(1, "rresp", slave_resp(rd_addr[r_cnt]), r_resp_o);
        end
        r_cnt++;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (m_aw_valid_o[p] && m_aw_ready_i[p]) begin
          check_true(0, m_aw_cnt < N_WR, "extra AW at a master port");
          if (m_aw_cnt < N_WR) begin
            compare_value(0, "aw port", wr_sel[m_aw_cnt], p);
            compare_value(0, "aw addr", wr_addr[m_aw_cnt], m_aw_addr_o);
            s_aw_addr[p][s_aw_cnt[p]] = m_aw_addr_o;
            s_aw_cnt[p]++;
          end
          m_aw_cnt++;
        end
        if (m_w_valid_o[p] && m_w_ready_i[p]) begin
          check_true(0, m_w_cnt < N_WR, "extra W beat at a master port");
          if (m_w_cnt < N_WR) begin
            compare_value(0, "w port", wr_sel[m_w_cnt], p);
            compare_value(0, "w data", wr_data[m_w_cnt], m_w_data_o);
            compare_value(0, "w strb", wr_strb[m_w_cnt], m_w_strb_o);
            s_w_cnt[p]++;
          end
          m_w_cnt++;
        end
        if (m_ar_valid_o[p] && m_ar_ready_i[p]) begin
          check_true(1, m_ar_cnt < N_ALL, "extra AR at a master port");
          if (m_ar_cnt < N_ALL) begin
            compare_value(1, "ar port", rd_sel[m_ar_cnt], p);
            compare_value(1, "ar addr", rd_addr[m_ar_cnt], m_ar_addr_o);
            s_ar_addr[p][s_ar_cnt[p]] = m_ar_addr_o;
            s_ar_cnt[p]++;
          end
          m_ar_cnt++;
        end
        if (m_b_valid_i[p] && m_b_ready_o[p]) b_done[p]++;
        if (m_r_valid_i[p] && m_r_ready_o[p]) r_done[p]++;
      end
    end
  end

  // ----------------------------------------------------------
  // sequence
  // ----------------------------------------------------------
  initial begin
    int b_total;
    int total_err;
    int total_chk;
    b_total   = 0;
    total_err = 0;
    total_chk = 0;
    for (int i = 0; i < N_WR; i++) begin
      wr_addr[i] = ADDR_W'($random(seed));
      wr_sel[i]  = SEL_W'(($random(seed) & 32'h7fff_ffff) % NUM_PORTS);
      wr_data[i] = $random(seed);
      wr_strb[i] = STRB_W'($random(seed));
    end
    for (int i = 0; i < N_ALL; i++) begin
      rd_addr[i] = ADDR_W'($random(seed));
      rd_sel[i]  = SEL_W'(($random(seed) & 32'h7fff_ffff) % NUM_PORTS);
    end
    rst_i = 1'b1;
    {aw_valid_i, w_valid_i, ar_valid_i, b_ready_i, r_ready_i} = '0;
    {aw_addr_i, ar_addr_i, aw_sel_i, ar_sel_i, w_data_i, w_strb_i} = '0;
    {m_aw_ready_i, m_w_ready_i, m_ar_ready_i, m_b_valid_i, m_r_valid_i} = '0;
    {m_b_resp_i, m_r_resp_i, m_r_data_i} = '0;
    ar_limit = N_RD;
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;
    wait_cycle();
    run = 1'b1;
    // tests 1 to 4 share one stream of mixed traffic
    while (b_cnt < N_WR || r_cnt < N_RD) wait_cycle();
    repeat (10) wait_cycle(); // room for a stray duplicate
    for (int p = 0; p < NUM_PORTS; p++) b_total += b_done[p];
    compare_value(3, "b count", N_WR, b_cnt);
    compare_value(3, "r count", N_RD, r_cnt);
    compare_value(3, "slave b count", N_WR, b_total);
    for (int t = 0; t < 4; t++) report_test(t);
    // AR stalls at MAX_TRANS while all slaves withhold R
    lim_base   = ar_xfer;
    limit_mode = 1'b1;
    hold_r     = 1'b1;
    ar_limit   = N_ALL;
    while (ar_xfer - lim_base < MAX_TRANS) wait_cycle();
    repeat (20) wait_cycle();
    compare_value(4, "ar at limit", MAX_TRANS, ar_xfer - lim_base);
    limit_mode = 1'b0;
    hold_r     = 1'b0;
    while (r_cnt < N_ALL) wait_cycle();
    report_test(4);
    for (int t = 0; t < 5; t++) begin
      total_err += errs[t];
      total_chk += checks[t];
    end
    $display("assertions: %0d failures", uut.u_sva.fail_cnt);
    total_err += uut.u_sva.fail_cnt;
    $display("total: %0d checks, %0d errors", total_chk, total_err);
    if (total_err == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog allows 200 cycles per transaction
  initial begin
    #((N_WR + N_ALL) * 200 * PERIOD);
    $display("timeout: transactions did not complete in time");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: tb/lite_demux_sva.sv
/*
  demux handshake checks
  one-hot master valids, AW held while stalled, quiet outputs
  in the first cycle after reset
*/
`timescale 1ns/1ns

module lite_demux_sva import demux_pkg::*; #(
  parameter int NUM_PORTS = NUM_PORTS_DEF
) (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic [NUM_PORTS-1:0] m_aw_valid_o,
  input logic [NUM_PORTS-1:0] m_aw_ready_i,
  input logic [NUM_PORTS-1:0] m_w_valid_o,
  input logic [NUM_PORTS-1:0] m_ar_valid_o,
  input logic                 w_ready_o,
  input logic                 b_valid_o,
  input logic                 r_valid_o
);

  int fail_cnt = 0; // failed assertions so far

  // one target port per channel at a time
  a_aw_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(m_aw_valid_o))
    else begin
      $error("m_aw_valid_o has more than one bit set");
      fail_cnt++;
    end
  a_w_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(m_w_valid_o))
    else begin
      $error("m_w_valid_o has more than one bit set");
      fail_cnt++;
    end
  a_ar_onehot: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(m_ar_valid_o))
    else begin
      $error("m_ar_valid_o has more than one bit set");
      fail_cnt++;
    end

  // stalled AW keeps its valid through the lock state
  a_aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (|(m_aw_valid_o & ~m_aw_ready_i)) |=> (m_aw_valid_o == $past(m_aw_valid_o)))
    else begin
      $error("m_aw_valid_o dropped before its transfer");
      fail_cnt++;
    end

  a_reset_quiet: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !(w_ready_o || b_valid_o || r_valid_o))
    else begin
      $error("W ready or a response valid high right after reset");
      fail_cnt++;
    end

endmodule

bind lite_demux_top lite_demux_sva #(.NUM_PORTS(NUM_PORTS)) u_sva (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .m_aw_valid_o (m_aw_valid_o),
  .m_aw_ready_i (m_aw_ready_i),
  .m_w_valid_o  (m_w_valid_o),
  .m_ar_valid_o (m_ar_valid_o),
  .w_ready_o    (w_ready_o),
  .b_valid_o    (b_valid_o),
  .r_valid_o    (r_valid_o)
);

// File: demux/lite_demux_top.sv
/*
  axi4-lite demux
  one slave port to NUM_PORTS master ports, target picked per AW / AR
  by a select; three select FIFOs keep W, B and R in order
*/
`timescale 1ns/1ns

module lite_demux_top import demux_pkg::*, axi_lite_pkg::*; #(
  parameter  int NUM_PORTS = NUM_PORTS_DEF,
  parameter  int MAX_TRANS = MAX_TRANS_DEF,
  localparam int SEL_W     = $clog2(NUM_PORTS) // port select width
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  // slave side
  input  logic                             aw_valid_i,
  output logic                             aw_ready_o,
  input  logic [ADDR_W-1:0]                aw_addr_i,
  input  logic [SEL_W-1:0]                 aw_sel_i,   // stable while aw_valid_i
  input  logic                             w_valid_i,
  output logic                             w_ready_o,
  input  logic [DATA_W-1:0]                w_data_i,
  input  logic [STRB_W-1:0]                w_strb_i,
  output logic                             b_valid_o,
  input  logic                             b_ready_i,
  output resp_e                            b_resp_o,
  input  logic                             ar_valid_i,
  output logic                             ar_ready_o,
  input  logic [ADDR_W-1:0]                ar_addr_i,
  input  logic [SEL_W-1:0]                 ar_sel_i,   // stable while ar_valid_i
  output logic                             r_valid_o,
  input  logic                             r_ready_i,
  output logic [DATA_W-1:0]                r_data_o,
  output resp_e                            r_resp_o,
  // master side, one bit / entry per port
  output logic [NUM_PORTS-1:0]             m_aw_valid_o,
  input  logic [NUM_PORTS-1:0]             m_aw_ready_i,
  output logic [ADDR_W-1:0]                m_aw_addr_o,
  output logic [NUM_PORTS-1:0]             m_w_valid_o,
  input  logic [NUM_PORTS-1:0]             m_w_ready_i,
  output logic [DATA_W-1:0]                m_w_data_o,
  output logic [STRB_W-1:0]                m_w_strb_o,
  input  logic [NUM_PORTS-1:0]             m_b_valid_i,
  output logic [NUM_PORTS-1:0]             m_b_ready_o,
  input  logic [NUM_PORTS-1:0][1:0]        m_b_resp_i,
  output logic [NUM_PORTS-1:0]             m_ar_valid_o,
  input  logic [NUM_PORTS-1:0]             m_ar_ready_i,
  output logic [ADDR_W-1:0]                m_ar_addr_o,
  input  logic [NUM_PORTS-1:0]             m_r_valid_i,
  output logic [NUM_PORTS-1:0]             m_r_ready_o,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0] m_r_data_i,
  input  logic [NUM_PORTS-1:0][1:0]        m_r_resp_i
);

  // ----------------------------------------------------------
  // internal wires
  // ----------------------------------------------------------
  logic             aw_issue, w_issue, ar_issue, b_take, r_take;
  logic             w_push, w_pop, b_pop, r_push, r_pop;
  logic             w_full, w_empty, b_full, b_empty, r_full, r_empty;
  logic             aw_sel_ready, w_sel_ready, ar_sel_ready;
  logic             b_sel_valid, r_sel_valid;
  logic [SEL_W-1:0] w_sel, b_sel, r_sel; // FIFO heads

  demux_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .aw_valid_i     (aw_valid_i),
    .w_valid_i      (w_valid_i),
    .ar_valid_i     (ar_valid_i),
    .b_ready_i      (b_ready_i),
    .r_ready_i      (r_ready_i),
    .aw_sel_ready_i (aw_sel_ready),
    .w_sel_ready_i  (w_sel_ready),
    .ar_sel_ready_i (ar_sel_ready),
    .b_sel_valid_i  (b_sel_valid),
    .r_sel_valid_i  (r_sel_valid),
    .w_full_i       (w_full),
    .w_empty_i      (w_empty),
    .b_full_i       (b_full),
    .b_empty_i      (b_empty),
    .r_full_i       (r_full),
    .r_empty_i      (r_empty),
    .aw_issue_o     (aw_issue),
    .w_issue_o      (w_issue),
    .b_take_o       (b_take),
    .r_take_o       (r_take),
    .ar_issue_o     (ar_issue),
    .w_push_o       (w_push),
    .w_pop_o        (w_pop),
    .b_pop_o        (b_pop),
    .r_push_o       (r_push),
    .r_pop_o        (r_pop),
    .aw_ready_o     (aw_ready_o),
    .w_ready_o      (w_ready_o),
    .b_valid_o      (b_valid_o),
    .ar_ready_o     (ar_ready_o),
    .r_valid_o      (r_valid_o)
  );

  // ----------------------------------------------------------
  // select FIFOs
  // ----------------------------------------------------------
  select_fifo #(.DEPTH(MAX_TRANS), .WIDTH(SEL_W)) u_w_fifo ( // AW order
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (w_push),
    .pop_i   (w_pop),
    .data_i  (aw_sel_i),
    .data_o  (w_sel),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  select_fifo #(.DEPTH(MAX_TRANS), .WIDTH(SEL_W)) u_b_fifo ( // W order
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (w_pop),  // W beat done, its port owes a B
    .pop_i   (b_pop),
    .data_i  (w_sel),
    .data_o  (b_sel),
    .full_o  (b_full),
    .empty_o (b_empty)
  );

  select_fifo #(.DEPTH(MAX_TRANS), .WIDTH(SEL_W)) u_r_fifo ( // AR order
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (r_push),
    .pop_i   (r_pop),
    .data_i  (ar_sel_i),
    .data_o  (r_sel),
    .full_o  (r_full),
    .empty_o (r_empty)
  );

  // ----------------------------------------------------------
  // datapath, all combinational
  // ----------------------------------------------------------
  req_fanout #(.NUM_PORTS(NUM_PORTS), .SEL_W(SEL_W)) u_fanout (
    .aw_issue_i     (aw_issue),
    .w_issue_i      (w_issue),
    .ar_issue_i     (ar_issue),
    .aw_sel_i       (aw_sel_i),
    .w_sel_i        (w_sel),
    .ar_sel_i       (ar_sel_i),
    .aw_addr_i      (aw_addr_i),
    .w_data_i       (w_data_i),
    .w_strb_i       (w_strb_i),
    .ar_addr_i      (ar_addr_i),
    .m_aw_ready_i   (m_aw_ready_i),
    .m_w_ready_i    (m_w_ready_i),
    .m_ar_ready_i   (m_ar_ready_i),
    .m_aw_valid_o   (m_aw_valid_o),
    .m_w_valid_o    (m_w_valid_o),
    .m_ar_valid_o   (m_ar_valid_o),
    .m_aw_addr_o    (m_aw_addr_o),
    .m_w_data_o     (m_w_data_o),
    .m_w_strb_o     (m_w_strb_o),
    .m_ar_addr_o    (m_ar_addr_o),
    .aw_sel_ready_o (aw_sel_ready),
    .w_sel_ready_o  (w_sel_ready),
    .ar_sel_ready_o (ar_sel_ready)
  );

  resp_mux #(.NUM_PORTS(NUM_PORTS), .SEL_W(SEL_W)) u_resp_mux (
    .b_sel_i       (b_sel),
    .r_sel_i       (r_sel),
    .b_take_i      (b_take),
    .r_take_i      (r_take),
    .m_b_valid_i   (m_b_valid_i),
    .m_b_resp_i    (m_b_resp_i),
    .m_r_valid_i   (m_r_valid_i),
    .m_r_data_i    (m_r_data_i),
    .m_r_resp_i    (m_r_resp_i),
    .b_sel_valid_o (b_sel_valid),
    .b_resp_o      (b_resp_o),
    .r_sel_valid_o (r_sel_valid),
    .r_data_o      (r_data_o),
    .r_resp_o      (r_resp_o),
    .m_b_ready_o   (m_b_ready_o),
    .m_r_ready_o   (m_r_ready_o)
  );

endmodule

// File: demux/demux_ctrl.sv
/*
  demux channel control
  AW valid lock, FIFO push/pop strobes and the issue and ready
  decisions of all five channels
*/
`timescale 1ns/1ns

module demux_ctrl import demux_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  input  logic aw_valid_i,
  input  logic w_valid_i,
  input  logic ar_valid_i,
  input  logic b_ready_i,
  input  logic r_ready_i,
  input  logic aw_sel_ready_i, // ready of the AW target port
  input  logic w_sel_ready_i,  // ready of the port at W FIFO head
  input  logic ar_sel_ready_i,
  input  logic b_sel_valid_i,  // valid of the port at B FIFO head
  input  logic r_sel_valid_i,
  input  logic w_full_i,
  input  logic w_empty_i,
  input  logic b_full_i,
  input  logic b_empty_i,
  input  logic r_full_i,
  input  logic r_empty_i,
  output logic aw_issue_o,
  output logic w_issue_o,
  output logic b_take_o,
  output logic r_take_o,
  output logic ar_issue_o,
  output logic w_push_o,
  output logic w_pop_o,        // doubles as B FIFO push
  output logic b_pop_o,
  output logic r_push_o,
  output logic r_pop_o,
  output logic aw_ready_o,
  output logic w_ready_o,
  output logic b_valid_o,
  output logic ar_ready_o,
  output logic r_valid_o
);

  aw_state_e aw_state_q, aw_state_d;

  // ----------------------------------------------------------
  // AW channel with valid lock
  // ----------------------------------------------------------
  always_comb begin
    aw_state_d = aw_state_q;
    aw_issue_o = 1'b0;
    aw_ready_o = 1'b0;
    w_push_o   = 1'b0;
    case (aw_state_q)
      AW_IDLE: begin
        // only issue with room for the select
        if (aw_valid_i && !w_full_i) begin
          aw_issue_o = 1'b1;
          w_push_o   = 1'b1; // select recorded on first issue
          if (aw_sel_ready_i) begin
            aw_ready_o = 1'b1;
          end else begin
            aw_state_d = AW_LOCKED; // keep valid up, no second push
          end
        end
      end
      AW_LOCKED: begin
        aw_issue_o = 1'b1; // master keeps aw_valid_i high by protocol
        if (aw_sel_ready_i) begin
          aw_ready_o = 1'b1;
          aw_state_d = AW_IDLE;
        end
      end
      default: aw_state_d = AW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_state_q <= AW_IDLE;
    end else begin
      aw_state_q <= aw_state_d;
    end
  end

  // ----------------------------------------------------------
  // W channel, needs its AW select and room in B FIFO
  // ----------------------------------------------------------
  assign w_issue_o = w_valid_i & ~w_empty_i & ~b_full_i;
  assign w_ready_o = ~w_empty_i & ~b_full_i & w_sel_ready_i;
  assign w_pop_o   = w_valid_i & w_ready_o; // beat done

  // B channel, in W order
  assign b_valid_o = ~b_empty_i & b_sel_valid_i;
  assign b_take_o  = ~b_empty_i & b_ready_i;
  assign b_pop_o   = b_valid_o & b_ready_i;

  // ----------------------------------------------------------
  // AR channel, limited by R FIFO depth
  // ----------------------------------------------------------
  assign ar_issue_o = ar_valid_i & ~r_full_i;
  assign ar_ready_o = ~r_full_i & ar_sel_ready_i;
  assign r_push_o   = ar_valid_i & ar_ready_o;

  // R channel, in AR order
  assign r_valid_o = ~r_empty_i & r_sel_valid_i;
  assign r_take_o  = ~r_empty_i & r_ready_i;
  assign r_pop_o   = r_valid_o & r_ready_i;

endmodule

// File: logic/resp_mux.sv
/*
  response mux
  picks B and R from the port at the head of their select FIFO
  and drives ready back to that port only
*/
`timescale 1ns/1ns

module resp_mux import demux_pkg::*, axi_lite_pkg::*; #(
  parameter int NUM_PORTS = NUM_PORTS_DEF,
  parameter int SEL_W     = $clog2(NUM_PORTS_DEF)
) (
  input  logic [SEL_W-1:0]                  b_sel_i,    // B FIFO head
  input  logic [SEL_W-1:0]                  r_sel_i,    // R FIFO head
  input  logic                              b_take_i,
  input  logic                              r_take_i,
  input  logic [NUM_PORTS-1:0]              m_b_valid_i,
  input  logic [NUM_PORTS-1:0][1:0]         m_b_resp_i,
  input  logic [NUM_PORTS-1:0]              m_r_valid_i,
  input  logic [NUM_PORTS-1:0][DATA_W-1:0]  m_r_data_i,
  input  logic [NUM_PORTS-1:0][1:0]         m_r_resp_i,
  output logic                              b_sel_valid_o,
  output resp_e                             b_resp_o,
  output logic                              r_sel_valid_o,
  output logic [DATA_W-1:0]                 r_data_o,
  output resp_e                             r_resp_o,
  output logic [NUM_PORTS-1:0]              m_b_ready_o,
  output logic [NUM_PORTS-1:0]              m_r_ready_o
);

  // ----------------------------------------------------------
  // B channel
  // ----------------------------------------------------------
  assign b_sel_valid_o = m_b_valid_i[b_sel_i];          // gated by FIFO state in ctrl
  assign b_resp_o      = resp_e'(m_b_resp_i[b_sel_i]);

  // ----------------------------------------------------------
  // R channel
  // ----------------------------------------------------------
  assign r_sel_valid_o = m_r_valid_i[r_sel_i];
  assign r_data_o      = m_r_data_i[r_sel_i];
  assign r_resp_o      = resp_e'(m_r_resp_i[r_sel_i]);

  // ready only towards the port whose response is expected next,
  // other ports keep their responses until their turn
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_ready
    assign m_b_ready_o[i] = b_take_i & (b_sel_i == SEL_W'(i));
    assign m_r_ready_o[i] = r_take_i & (r_sel_i == SEL_W'(i));
  end

endmodule

// File: logic/req_fanout.sv
/*
  request fan-out
  broadcasts AW, W and AR payloads to all master ports, raises the
  valid of the selected port only and hands back that port's ready
*/
`timescale 1ns/1ns

module req_fanout import demux_pkg::*, axi_lite_pkg::*; #(
  parameter int NUM_PORTS = NUM_PORTS_DEF,
  parameter int SEL_W     = $clog2(NUM_PORTS_DEF)
) (
  input  logic                 aw_issue_i,
  input  logic                 w_issue_i,
  input  logic                 ar_issue_i,
  input  logic [SEL_W-1:0]     aw_sel_i,
  input  logic [SEL_W-1:0]     w_sel_i,   // W FIFO head
  input  logic [SEL_W-1:0]     ar_sel_i,
  input  logic [ADDR_W-1:0]    aw_addr_i,
  input  logic [DATA_W-1:0]    w_data_i,
  input  logic [STRB_W-1:0]    w_strb_i,
  input  logic [ADDR_W-1:0]    ar_addr_i,
  input  logic [NUM_PORTS-1:0] m_aw_ready_i,
  input  logic [NUM_PORTS-1:0] m_w_ready_i,
  input  logic [NUM_PORTS-1:0] m_ar_ready_i,
  output logic [NUM_PORTS-1:0] m_aw_valid_o,
  output logic [NUM_PORTS-1:0] m_w_valid_o,
  output logic [NUM_PORTS-1:0] m_ar_valid_o,
  output logic [ADDR_W-1:0]    m_aw_addr_o,
  output logic [DATA_W-1:0]    m_w_data_o,
  output logic [STRB_W-1:0]    m_w_strb_o,
  output logic [ADDR_W-1:0]    m_ar_addr_o,
  output logic                 aw_sel_ready_o,
  output logic                 w_sel_ready_o,
  output logic                 ar_sel_ready_o
);

  // payloads go to every port, only one valid qualifies them
  assign m_aw_addr_o = aw_addr_i;
  assign m_w_data_o  = w_data_i;
  assign m_w_strb_o  = w_strb_i;
  assign m_ar_addr_o = ar_addr_i;

  // ----------------------------------------------------------
  // one-hot valid decode per channel
  // ----------------------------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_valid
    assign m_aw_valid_o[i] = aw_issue_i & (aw_sel_i == SEL_W'(i));
    assign m_w_valid_o[i]  = w_issue_i  & (w_sel_i  == SEL_W'(i));
    assign m_ar_valid_o[i] = ar_issue_i & (ar_sel_i == SEL_W'(i));
  end

  // ready of the addressed port back to the controller
  assign aw_sel_ready_o = m_aw_ready_i[aw_sel_i];
  assign w_sel_ready_o  = m_w_ready_i[w_sel_i];
  assign ar_sel_ready_o = m_ar_ready_i[ar_sel_i];

endmodule

// File: logic/select_fifo.sv
/*
  select FIFO
  circular buffer of port selects, head visible at data_o,
  full and empty flags for the channel control
*/
`timescale 1ns/1ns

module select_fifo import demux_pkg::*; #(
  parameter int DEPTH = MAX_TRANS_DEF,
  parameter int WIDTH = $clog2(NUM_PORTS_DEF)
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH]; // stored selects
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push, do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem[rd_ptr_q]; // head of queue

  // never write a full or read an empty buffer
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin // wrap at DEPTH - 1
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: common/demux_pkg.sv
/*
  demux configuration
  default port count and transaction depth, and the state type
  of the AW valid lock
*/
package demux_pkg;

  // defaults picked up by the top level
  parameter int NUM_PORTS_DEF = 4; // master ports, at least 2
  parameter int MAX_TRANS_DEF = 4; // open transactions per channel

  // AW lock: select already pushed, AW still waiting for ready
  typedef enum logic {
    AW_IDLE   = 1'b0,
    AW_LOCKED = 1'b1
  } aw_state_e;

endpackage

// File: common/axi_lite_pkg.sv
/*
  axi4-lite bus description
  address, data and strobe widths shared by the demux and its
  testbench, plus the two-bit response code of the B and R channels
*/
package axi_lite_pkg;

  // ----------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------
  parameter int ADDR_W = 16;         // byte address
  parameter int DATA_W = 32;         // one data beat
  parameter int STRB_W = DATA_W / 8; // one strobe per byte lane

  // ----------------------------------------------------------
  // response code, as carried on bresp / rresp
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    OKAY   = 2'b00, // normal access done
    EXOKAY = 2'b01, // exclusive ok, never produced on axi-lite
    SLVERR = 2'b10, // slave reached, access failed
    DECERR = 2'b11  // no slave at that address
  } resp_e;

endpackage
